/* common/trace_pkg.sv */
// shared widths, codes, register map and control word layout for the trace trigger
package trace_pkg;

  localparam int data_w  = 32;  // axi data width
  localparam int addr_w  = 8;   // byte address
  localparam int buf_w   = 64;  // history depth in bits
  localparam int rules   = 8;
  localparam int count_w = 8;
  localparam int trace_w = 4;

  // trace port width codes, 3 acts as width_4
  localparam logic [1:0] width_1 = 2'd0;
  localparam logic [1:0] width_2 = 2'd1;
  localparam logic [1:0] width_4 = 2'd2;

  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

  // register byte addresses
  localparam logic [addr_w-1:0] addr_ctrl      = 8'h00;
  localparam logic [addr_w-1:0] addr_status    = 8'h04;  // read only
  localparam logic [addr_w-1:0] addr_mbuf_lo   = 8'h08;  // read only
  localparam logic [addr_w-1:0] addr_mbuf_hi   = 8'h0C;  // read only
  localparam logic [addr_w-1:0] addr_count_lo  = 8'h10;  // rules 0..3
  localparam logic [addr_w-1:0] addr_count_hi  = 8'h14;  // rules 4..7
  localparam logic [addr_w-1:0] addr_rule_base = 8'h40;  // 16 bytes per rule

  // bus slave states
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_wresp = 2'd1;
  localparam logic [1:0] st_rresp = 2'd2;

  // control word, seen either as the bus word or as its fields
  typedef union packed {
    logic [data_w-1:0] raw;
    struct packed {
      logic [data_w-13:0] reserved;
      logic               clear;          // self-clearing, never stored
      logic               toggle_mode;
      logic [1:0]         width_code;
      logic [rules-1:0]   pattern_enable;
    } fields;
  } ctrl_word_u;

endpackage

/* logic/axi_lite_slave.sv */
// AXI4-Lite slave front end, turns each accepted transaction into one register strobe
`timescale 1ns/100ps

module axi_lite_slave
  import trace_pkg::*;
(
  input  logic              ext_clock,
  input  logic              resetn,
  // write address and data
  input  logic [addr_w-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [data_w-1:0] wdata,
  input  logic              wvalid,
  output logic              wready,
  // write response
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  // read address and data
  input  logic [addr_w-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  // register side
  output logic [addr_w-1:0] reg_addr,
  output logic [data_w-1:0] reg_wdata,
  output logic              reg_write,
  output logic              reg_read,
  input  logic [data_w-1:0] reg_rdata,
  input  logic [1:0]        reg_resp
);

  logic [1:0] state;
  logic       write_go;
  logic       read_go;

  // accept only when address and data are both offered, write first
  assign write_go = (state == st_idle) && awvalid && wvalid;
  assign read_go  = (state == st_idle) && !write_go && arvalid;

  assign awready = write_go;
  assign wready  = write_go;
  assign arready = read_go;

  assign reg_write = write_go;  // single-cycle strobes
  assign reg_read  = read_go;
  assign reg_addr  = write_go ? awaddr : araddr;
  assign reg_wdata = wdata;

  assign bvalid = (state == st_wresp);
  assign rvalid = (state == st_rresp);

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (write_go) begin
            state <= st_wresp;
          end else if (read_go) begin
            state <= st_rresp;
          end
        end
        st_wresp: begin
          if (bready) begin
            state <= st_idle;  // response taken
          end
        end
        st_rresp: begin
          if (rready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // response payload, held stable while waiting for ready
  always_ff @(posedge ext_clock) begin
    if (write_go) begin
      bresp <= reg_resp;
    end
    if (read_go) begin
      rdata <= reg_rdata;
      rresp <= reg_resp;
    end
  end

endmodule

/* logic/trace_regs.sv */
// register file for the trace trigger, holds control and rule words and builds readback
`timescale 1ns/100ps

module trace_regs
  import trace_pkg::*;
(
  input  logic                     ext_clock,
  input  logic                     resetn,
  input  logic [addr_w-1:0]        reg_addr,
  input  logic [data_w-1:0]        reg_wdata,
  input  logic                     reg_write,
  input  logic                     reg_read,
  input  logic [rules-1:0]         match_status,
  input  logic [buf_w-1:0]         match_buffer,
  input  logic [rules*count_w-1:0] counts,
  output logic [data_w-1:0]        reg_rdata,
  output logic [1:0]               reg_resp,
  output logic [rules-1:0]         pattern_enable,
  output logic [1:0]               width_code,
  output logic                     toggle_mode,
  output logic                     clear,
  output logic [rules*buf_w-1:0]   patterns,
  output logic [rules*buf_w-1:0]   masks
);

  ctrl_word_u ctrl_q;
  ctrl_word_u wr_word;
  ctrl_word_u ctrl_next;

  logic [data_w-1:0]            rule_words [rules*4];  // pat lo, pat hi, mask lo, mask hi
  logic [addr_w-1:0]            rule_off;
  logic [$clog2(rules*4)-1:0]   rule_idx;
  logic                         rule_sel;
  logic                         ctrl_sel;
  logic                         ro_sel;
  logic                         clear_q;

  assign wr_word  = reg_wdata;
  assign rule_off = reg_addr - addr_rule_base;
  assign rule_idx = rule_off[$clog2(rules*4)+1:2];

  // address decode
  assign ctrl_sel = (reg_addr == addr_ctrl);
  assign rule_sel = (reg_addr >= addr_rule_base) && (rule_off < rules*16) &&
                    (reg_addr[1:0] == 2'b00);
  assign ro_sel   = reg_addr inside {addr_status, addr_mbuf_lo, addr_mbuf_hi,
                                     addr_count_lo, addr_count_hi};

  always_comb begin
    ctrl_next = wr_word;
    ctrl_next.fields.clear = 1'b0;  // clear only acts as a pulse
  end

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      ctrl_q  <= '0;
      clear_q <= 1'b0;
      for (int i = 0; i < rules*4; i++) begin
        rule_words[i] <= '0;
      end
    end else begin
      clear_q <= reg_write && ctrl_sel && wr_word.fields.clear;
      if (reg_write && ctrl_sel) begin
        ctrl_q <= ctrl_next;
      end
      if (reg_write && rule_sel) begin
        rule_words[rule_idx] <= reg_wdata;
      end
    end
  end

  // read mux, unmapped reads give zero
  always_comb begin
    case (reg_addr)
      addr_ctrl:     reg_rdata = ctrl_q.raw;
      addr_status:   reg_rdata = data_w'(match_status);
      addr_mbuf_lo:  reg_rdata = match_buffer[data_w-1:0];
      addr_mbuf_hi:  reg_rdata = match_buffer[buf_w-1:data_w];
      addr_count_lo: reg_rdata = counts[data_w-1:0];
      addr_count_hi: reg_rdata = counts[2*data_w-1:data_w];
      default:       reg_rdata = rule_sel ? rule_words[rule_idx] : '0;
    endcase
  end

  always_comb begin
    reg_resp = resp_okay;
    if (reg_write && !(ctrl_sel || rule_sel)) begin
      reg_resp = resp_slverr;  // read-only or unmapped
    end else if (reg_read && !(ctrl_sel || rule_sel || ro_sel)) begin
      reg_resp = resp_slverr;
    end
  end

  assign pattern_enable = ctrl_q.fields.pattern_enable;
  assign width_code     = ctrl_q.fields.width_code;
  assign toggle_mode    = ctrl_q.fields.toggle_mode;
  assign clear          = clear_q;

  for (genvar g = 0; g < rules; g++) begin : g_rule
    assign patterns[g*buf_w +: buf_w] = {rule_words[4*g+1], rule_words[4*g]};
    assign masks[g*buf_w +: buf_w]    = {rule_words[4*g+3], rule_words[4*g+2]};
  end

endmodule

/* trigger/trace_shift_buffer.sv */
// trace history shift register, takes 1, 2 or 4 new bits per enabled beat
`timescale 1ns/100ps

module trace_shift_buffer
  import trace_pkg::*;
(
  input  logic               ext_clock,
  input  logic               resetn,
  input  logic               clear,
  input  logic [trace_w-1:0] trace_data,
  input  logic               trace_enable,
  input  logic [1:0]         width_code,
  output logic [buf_w-1:0]   history
);

  logic [buf_w-1:0] history_next;

  // newest bits enter at the lsb end
  always_comb begin
    case (width_code)
      width_1: history_next = {history[buf_w-2:0], trace_data[0]};
      width_2: history_next = {history[buf_w-3:0], trace_data[1:0]};
      default: history_next = {history[buf_w-trace_w-1:0], trace_data};  // 4-bit port
    endcase
  end

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      history <= '0;
    end else if (clear) begin
      history <= '0;
    end else if (trace_enable) begin
      history <= history_next;
    end
  end

endmodule

/* trigger/trace_matcher.sv */
// masked pattern compare over all rules, drives the trigger and latches the last match
`timescale 1ns/100ps

module trace_matcher
  import trace_pkg::*;
(
  input  logic                   ext_clock,
  input  logic                   resetn,
  input  logic                   clear,
  input  logic [buf_w-1:0]       history,
  input  logic [rules*buf_w-1:0] patterns,
  input  logic [rules*buf_w-1:0] masks,
  input  logic [rules-1:0]       pattern_enable,
  input  logic                   toggle_mode,
  output logic [rules-1:0]       hits,
  output logic                   trig_out,
  output logic [rules-1:0]       match_status,
  output logic [buf_w-1:0]       match_buffer
);

  logic [rules-1:0] hit_now;
  logic             any_hit;

  // a rule hits when every masked bit agrees with its pattern
  always_comb begin
    for (int i = 0; i < rules; i++) begin
      hit_now[i] = pattern_enable[i] &&
                   (((history ^ patterns[i*buf_w +: buf_w]) & masks[i*buf_w +: buf_w]) == '0);
    end
  end

  assign any_hit = |hit_now;

  always_ff @(posedge ext_clock or negedge resetn) begin
    if (!resetn) begin
      hits         <= '0;
      trig_out     <= 1'b0;
      match_status <= '0;
      match_buffer <= '0;
    end else if (clear) begin
      hits         <= '0;  // drops the hit in flight
      trig_out     <= 1'b0;
      match_status <= '0;
      match_buffer <= '0;
    end else begin
      hits <= hit_now;
      if (toggle_mode) begin
        if (any_hit) begin
          trig_out <= ~trig_out;  // one flip per hit cycle
        end
      end else begin
        trig_out <= any_hit;
      end
      if (any_hit) begin
        match_status <= hit_now;
        match_buffer <= history;  // snapshot at match
      end
    end
  end

endmodule

/* trigger/match_counters.sv */
// per-rule hit counters that stop at full scale, zeroed by clear
`timescale 1ns/100ps

module match_counters
  import trace_pkg::*;
(
  input  logic                     ext_clock,
  input  logic                     resetn,
  input  logic                     clear,
  input  logic [rules-1:0]         hits,
  output logic [rules*count_w-1:0] counts
);

  for (genvar g = 0; g < rules; g++) begin : g_cnt
    logic [count_w-1:0] cnt;

    always_ff @(posedge ext_clock or negedge resetn) begin
      if (!resetn) begin
        cnt <= '0;
      end else if (clear) begin
        cnt <= '0;
      end else if (hits[g] && (cnt != {count_w{1'b1}})) begin
        cnt <= cnt + 1'b1;  // saturates at 255
      end
    end

    assign counts[g*count_w +: count_w] = cnt;
  end

endmodule

/* logic/trace_trigger_top.sv */
// top level of the trace trigger, connects the AXI4-Lite slave, registers and match path
`timescale 1ns/100ps

module trace_trigger_top
  import trace_pkg::*;
(
  input  logic               ext_clock,
  input  logic               resetn,
  input  logic [addr_w-1:0]  awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [data_w-1:0]  wdata,
  input  logic               wvalid,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [addr_w-1:0]  araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [data_w-1:0]  rdata,
  output logic [1:0]         rresp,
  output logic               rvalid,
  input  logic               rready,
  input  logic [trace_w-1:0] trace_data,
  input  logic               trace_enable,
  output logic               trig_out
);

  logic [addr_w-1:0]        reg_addr;
  logic [data_w-1:0]        reg_wdata;
  logic                     reg_write;
  logic                     reg_read;
  logic [data_w-1:0]        reg_rdata;
  logic [1:0]               reg_resp;
  logic [rules-1:0]         pattern_enable;
  logic [1:0]               width_code;
  logic                     toggle_mode;
  logic                     clear;
  logic [rules*buf_w-1:0]   patterns;
  logic [rules*buf_w-1:0]   masks;
  logic [buf_w-1:0]         history;
  logic [rules-1:0]         hits;
  logic [rules-1:0]         match_status;
  logic [buf_w-1:0]         match_buffer;
  logic [rules*count_w-1:0] counts;

  axi_lite_slave u_axi (.*);

  trace_regs u_regs (.*);

  trace_shift_buffer u_shift (.*);

  trace_matcher u_match (.*);

  match_counters u_count (.*);

endmodule

/* verification/trace_trigger_chk.sv */
// bound protocol and clear checks for the trace trigger top, attached with bind below
`timescale 1ns/100ps

module trace_trigger_chk
  import trace_pkg::*;
(
  input logic                     ext_clock,
  input logic                     resetn,
  input logic                     bvalid,
  input logic                     bready,
  input logic                     rvalid,
  input logic                     rready,
  input logic [data_w-1:0]        rdata,
  input logic                     awready,
  input logic                     arready,
  input logic                     clear,
  input logic [rules*count_w-1:0] counts
);

  // responses stay up until taken
  a_bvalid_hold : assert property (@(posedge ext_clock) disable iff (!resetn)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold : assert property (@(posedge ext_clock) disable iff (!resetn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  a_one_channel : assert property (@(posedge ext_clock) disable iff (!resetn)
    !(awready && arready))
    else $error("awready and arready high together");

  a_clear_counts : assert property (@(posedge ext_clock) disable iff (!resetn)
    clear |=> counts == '0)
    else $error("counts not zero after clear");

endmodule

bind trace_trigger_top trace_trigger_chk u_chk (.*);

/* verification/trace_trigger_tb.sv */
// testbench for trace_trigger_top, runs a stimulus table over AXI4-Lite and the trace port
`timescale 1ns/100ps

module trace_trigger_tb;
  import trace_pkg::*;

  localparam int op_wr = 0, op_rd = 1, op_snap = 2, op_beat = 3, op_idle = 4;

  typedef struct {
    int                op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;   // beat: nibble in 3:0, random bits in 7:4
    logic [data_w-1:0] exp;    // beat: bit 0 takes the history snapshot
    logic [1:0]        resp;
    logic              trig;
    int                stall;  // ready held low this many cycles
  } row_t;

  logic ext_clock = 0, resetn = 0;
  logic [addr_w-1:0] awaddr = '0, araddr = '0;
  logic [data_w-1:0] wdata = '0;
  logic awvalid = 0, wvalid = 0, bready = 0, arvalid = 0, rready = 0;
  logic [trace_w-1:0] trace_data = '0;
  logic trace_enable = 0;
  logic awready, wready, bvalid, arready, rvalid, trig_out;
  logic [1:0] bresp, rresp;
  logic [data_w-1:0] rdata;

  row_t rows[$];
  bit table_ready = 0;
  integer seed = 24;
  logic [buf_w-1:0] model_hist = '0;
  logic [buf_w-1:0] snap = '0;
  logic [1:0] model_width = width_1;

  trace_trigger_top dut0 (.*);

  always #20 ext_clock = ~ext_clock;

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, logic [data_w-1:0] exp, logic [data_w-1:0] act);
    if (act !== exp)
      fail_now($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp)
      fail_now($sformatf("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act));
  endtask

  task automatic check_trig(logic exp);
    if (trig_out !== exp)
      fail_now($sformatf("mismatch at %0t: trig_out expected %b got %b", $time, exp, trig_out));
  endtask

  task automatic push_row(int op, logic [7:0] a, logic [31:0] d, logic [31:0] e,
                          logic [1:0] r, logic t, int s);
    row_t x;
    x = '{op, a, d, e, r, t, s};
    rows.push_back(x);
  endtask

  task automatic push_write(logic [7:0] a, logic [31:0] d, logic [1:0] r = resp_okay);
    push_row(op_wr, a, d, 0, r, 0, 0);
  endtask

  task automatic push_read(logic [7:0] a, logic [31:0] e, logic [1:0] r = resp_okay);
    push_row(op_rd, a, 0, e, r, 0, 0);
  endtask

  task automatic push_beats(logic [7:0] b0, logic [7:0] b1, logic [7:0] b2,
                            logic [7:0] b3, logic [7:0] brk, logic tog);
    push_row(op_beat, 0, b0, 0, 0, 0, 0);  // trig still at its old level
    push_row(op_beat, 0, b1, 0, 0, 0, 0);
    push_row(op_beat, 0, b2, 0, 0, 0, 0);
    push_row(op_beat, 0, b3, 1, 0, 0, 0);  // matching beat
    push_row(op_beat, 0, brk, 0, 0, 1, 0);   // hit seen one edge later
    push_row(op_idle, 0, 2, 0, 0, tog, 0);
  endtask

  task automatic push_snap();
    push_row(op_snap, addr_mbuf_lo, 0, 0, resp_okay, 0, 0);
    push_row(op_snap, addr_mbuf_hi, 0, 0, resp_okay, 0, 0);
  endtask

  task automatic build_table();
    logic [31:0] v;
    // register access with back-pressure
    push_write(addr_ctrl, 32'h0000_0E55);
    push_read(addr_ctrl, 32'h0000_0655);
    for (int i = 0; i < rules*4; i++) begin
      v = 32'h5A5A_0000 ^ (i * 32'h0103_0507);
      push_row(op_wr, addr_rule_base + 4*i, v, 0, resp_okay, 0, (i == 5) ? 3 : 0);
    end
    for (int i = 0; i < rules*4; i++) begin
      v = 32'h5A5A_0000 ^ (i * 32'h0103_0507);
      push_row(op_rd, addr_rule_base + 4*i, 0, v, resp_okay, 0, (i == 9) ? 2 : 0);
    end
    push_row(op_wr, addr_status, 32'h1234, 0, resp_slverr, 0, 2);
    push_row(op_rd, 8'h30, 0, 0, resp_slverr, 0, 3);
    // 4-bit port, pulse mode, rule 2
    push_write(8'h60, 32'h0000_ABCD);
    push_write(8'h64, 0);
    push_write(8'h68, 32'h0000_F0FF);
    push_write(8'h6C, 0);
    push_write(addr_ctrl, 32'h0000_0A04);
    push_beats(8'h0A, 8'hFB, 8'h0C, 8'h0D, 8'h00, 0);
    push_read(addr_status, 32'h04);
    push_snap();
    push_read(addr_count_lo, 32'h0001_0000);
    // 1-bit port, rule 0
    push_write(8'h40, 32'h0000_000B);
    push_write(8'h44, 0);
    push_write(8'h48, 32'h0000_000F);
    push_write(8'h4C, 0);
    push_write(addr_ctrl, 32'h0000_0801);
    push_beats(8'hE1, 8'hE0, 8'hE1, 8'hE1, 8'hE0, 0);
    push_read(addr_status, 32'h01);
    push_snap();
    push_read(addr_count_lo, 32'h0000_0001);
    // 2-bit port, rule 5
    push_write(8'h90, 32'h0000_00E4);
    push_write(8'h94, 0);
    push_write(8'h98, 32'h0000_00FF);
    push_write(8'h9C, 0);
    push_write(addr_ctrl, 32'h0000_0920);
    push_beats(8'hC3, 8'hC2, 8'hC1, 8'hC0, 8'hC1, 0);
    push_read(addr_status, 32'h20);
    push_snap();
    push_read(addr_count_hi, 32'h0000_0100);
    // toggle mode, rules 1 and 3 on the same beat
    push_write(8'h50, 32'h0000_0077);
    push_write(8'h54, 0);
    push_write(8'h58, 32'h0000_00FF);
    push_write(8'h5C, 0);
    push_write(8'h70, 32'h0000_0577);
    push_write(8'h74, 0);
    push_write(8'h78, 32'h0000_0FFF);
    push_write(8'h7C, 0);
    push_write(addr_ctrl, 32'h0000_0E0A);
    push_beats(8'h00, 8'h05, 8'h07, 8'h07, 8'h00, 1);
    push_row(op_idle, 0, 1, 0, 0, 1, 0);  // stays flipped
    push_read(addr_status, 32'h0A);
    push_snap();
    push_read(addr_count_lo, 32'h0100_0100);
    // saturation, rule 6 is disabled
    for (int a = 8'h80; a <= 8'hAC; a += 4) begin
      push_write(a, (a[3] && (a < 8'h90 || a >= 8'hA0)) ? 32'hFFFF_FFFF : 32'h0);
    end
    push_write(addr_ctrl, 32'h0000_0A10);
    for (int i = 0; i < 300; i++) begin
      push_row(op_beat, 0, 0, 0, 0, 1, 0);
    end
    push_read(addr_count_hi, 32'h0000_00FF);
    push_read(addr_status, 32'h10);
    push_write(addr_ctrl, 32'h0000_0800);
    push_row(op_idle, 0, 2, 0, 0, 0, 0);
    push_read(addr_count_lo, 0);
    push_read(addr_count_hi, 0);
    push_read(addr_status, 0);
    push_read(addr_mbuf_lo, 0);
    push_read(addr_mbuf_hi, 0);
  endtask

  task automatic axi_write(row_t x);
    awaddr = x.addr;
    wdata = x.data;
    awvalid = 1;
    wvalid = 1;
    do @(negedge ext_clock); while (!awready);
    if (wready !== 1'b1)
      fail_now("wready did not rise together with awready");
    @(posedge ext_clock);
    #2 awvalid = 0;
    wvalid = 0;
    repeat (x.stall) begin
      @(posedge ext_clock);
      #2;
    end
    bready = 1;
    do @(negedge ext_clock); while (!bvalid);
    check_resp("bresp", x.resp, bresp);
    @(posedge ext_clock);
    #2 bready = 0;
    if (x.addr == addr_ctrl && x.resp == resp_okay) begin
      model_width = x.data[9:8];
      if (x.data[11]) model_hist = '0;
    end
  endtask

  task automatic axi_read(row_t x);
    logic [data_w-1:0] e;
    e = x.exp;
    if (x.op == op_snap) e = (x.addr == addr_mbuf_lo) ? snap[31:0] : snap[63:32];
    araddr = x.addr;
    arvalid = 1;
    do @(negedge ext_clock); while (!arready);
    @(posedge ext_clock);
    #2 arvalid = 0;
    repeat (x.stall) begin
      @(posedge ext_clock);
      #2;
    end
    rready = 1;
    do @(negedge ext_clock); while (!rvalid);
    check_word("rdata", e, rdata);
    check_resp("rresp", x.resp, rresp);
    @(posedge ext_clock);
    #2 rready = 0;
  endtask

  task automatic trace_beat(row_t x);
    logic [31:0] r;
    logic [trace_w-1:0] n;
    r = $random(seed);
    n = (x.data[3:0] & ~x.data[7:4]) | (r[3:0] & x.data[7:4]);  // ignored bits random
    trace_data = n;
    trace_enable = 1;
    case (model_width)
      width_1: model_hist = {model_hist[buf_w-2:0], n[0]};
      width_2: model_hist = {model_hist[buf_w-3:0], n[1:0]};
      default: model_hist = {model_hist[buf_w-5:0], n};
    endcase
    if (x.exp[0]) snap = model_hist;
    @(posedge ext_clock);
    #2 trace_enable = 0;
    check_trig(x.trig);
  endtask

  initial begin
    wait (table_ready);
    #(rows.size() * 30 * 40);
    $display("timeout: the test did not finish in time");
    $display("Verification failed");
    $fatal(1);
  end

  initial begin
    build_table();
    table_ready = 1;
    repeat (2) @(posedge ext_clock);
    #2 resetn = 1;
    foreach (rows[i]) begin
      case (rows[i].op)
        op_wr:   axi_write(rows[i]);
        op_beat: trace_beat(rows[i]);
        op_idle: begin
          repeat (rows[i].data) @(posedge ext_clock);
          #2 check_trig(rows[i].trig);
        end
        default: axi_read(rows[i]);
      endcase
    end
    $display("Verification passed");
    $finish;
  end

endmodule

/* trace_trigger.f */
common/trace_pkg.sv
logic/axi_lite_slave.sv
logic/trace_regs.sv
trigger/trace_shift_buffer.sv
trigger/trace_matcher.sv
trigger/match_counters.sv
logic/trace_trigger_top.sv
verification/trace_trigger_chk.sv
verification/trace_trigger_tb.sv
